//--- list.f
logic/mem_pkg.sv
logic/lsu_l1d.sv
logic/ifu_l1i.sv
logic/bus_arbiter.sv
logic/bus_memory.sv
logic/mem_top.sv
tests/mem_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_top_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_TEXT ?= TB PASSED

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/mem_top_tb.sv
`timescale 1ns/1ns

module mem_top_tb;
  import mem_pkg::*;

  localparam int clock_period = 40;
  localparam int mem_latency = 3;
  localparam int mem_words = 1024;
  localparam int word_bits = $clog2(mem_words);
  localparam int max_wait = 2 * (mem_latency + 2);  // arbiter wait plus own miss
  localparam int watchdog_cycles = 400;

  logic            clock;
  logic            reset;
  logic            data_invalidate;
  logic            inst_invalidate;
  logic            load_valid;
  logic [xlen-1:0] load_addr;
  load_op_t        load_op;
  logic            load_done;
  logic [xlen-1:0] load_data;
  logic            store_valid;
  logic [xlen-1:0] store_addr;
  logic [xlen-1:0] store_data;
  store_op_t       store_op;
  logic            store_done;
  logic            fetch_valid;
  logic [xlen-1:0] fetch_pc;
  logic            fetch_done;
  logic [xlen-1:0] fetch_instr;

  logic [xlen-1:0] shadow [mem_words];  // expected memory contents
  logic [7:0]      lfsr_state = 8'd8;
  logic [xlen-1:0] exp_load;
  logic [xlen-1:0] exp_fetch;
  logic            want_hit;
  logic            want_miss;
  logic            want_fetch_hit;
  logic            want_fetch_miss;
  logic            load_uncached;
  int              load_age;  // cycles the request has waited
  int              store_age;
  int              fetch_age;
  logic            load_seen;  // done as the last edge took it
  logic            store_seen;
  logic            fetch_seen;
  int              word_a;
  int              word_b;
  int              word_u;
  logic [xlen-1:0] addr_a;
  logic [xlen-1:0] addr_b;
  logic [xlen-1:0] addr_u;
  logic [xlen-1:0] rand_word;
  logic [1:0]      rand_lane;

  mem_top #(.MEM_LATENCY(mem_latency), .MEM_WORDS(mem_words)) uut (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_cycles * clock_period);
    stop_run("timeout: the tests did not finish in time");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return (state >> 1) ^ (state[0] ? 8'hb8 : 8'h00);
  endfunction

  // one lfsr step per bit
  function automatic logic [xlen-1:0] draw_bits(input int count);
    logic [xlen-1:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[xlen-2:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic int word_index(input logic [xlen-1:0] addr);
    return int'(addr[word_bits+1:2]);
  endfunction

  function automatic logic [xlen-1:0] expected_load(input logic [xlen-1:0] word,
                                                    input logic [1:0] offset,
                                                    input load_op_t op);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*offset +: 8];
    h = offset[1] ? word[31:16] : word[15:0];
    case (op)
      lb:      return {{24{b[7]}}, b};
      lbu:     return {24'h0, b};
      lh:      return {{16{h[15]}}, h};
      lhu:     return {16'h0, h};
      default: return word;
    endcase
  endfunction

  task automatic issue_load(input logic [xlen-1:0] addr, input load_op_t op,
                            input logic hit, input logic miss);
    load_addr = addr;
    load_op = op;
    exp_load = expected_load(shadow[word_index(addr)], addr[1:0], op);
    want_hit = hit;
    want_miss = miss;
    load_valid = 1'b1;
    @(negedge clock);
    while (!load_seen) @(negedge clock);
    load_valid = 1'b0;
    want_hit = 1'b0;
    want_miss = 1'b0;
    repeat (2) @(negedge clock);  // let the wait state pass
  endtask

  task automatic issue_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                             input store_op_t op);
    int w;
    w = word_index(addr);
    store_addr = addr;
    store_data = data;
    store_op = op;
    store_valid = 1'b1;
    @(negedge clock);
    while (!store_seen) @(negedge clock);
    store_valid = 1'b0;
    case (op)
      sb: shadow[w][8*addr[1:0] +: 8] = data[7:0];
      sh: begin
        if (addr[1]) shadow[w][31:16] = data[15:0];
        else shadow[w][15:0] = data[15:0];
      end
      default: shadow[w] = data;
    endcase
    repeat (2) @(negedge clock);
  endtask

  task automatic issue_fetch(input logic [xlen-1:0] pc, input logic hit, input logic miss);
    fetch_pc = pc;
    exp_fetch = shadow[word_index(pc)];
    want_fetch_hit = hit;
    want_fetch_miss = miss;
    fetch_valid = 1'b1;
    @(negedge clock);
    while (!fetch_seen) @(negedge clock);
    fetch_valid = 1'b0;
    want_fetch_hit = 1'b0;
    want_fetch_miss = 1'b0;
    repeat (2) @(negedge clock);
  endtask

  task automatic pulse_invalidate(input logic inst_side);
    if (inst_side) inst_invalidate = 1'b1;
    else data_invalidate = 1'b1;
    @(negedge clock);
    inst_invalidate = 1'b0;
    data_invalidate = 1'b0;
  endtask

  // every size and legal offset of one word
  task automatic check_every_lane(input logic [xlen-1:0] base, input logic cached);
    for (int off = 0; off < 4; off++) begin
      issue_load(base + off, lb, cached, !cached);
      issue_load(base + off, lbu, cached, !cached);
    end
    for (int off = 0; off < 4; off += 2) begin
      issue_load(base + off, lh, cached, !cached);
      issue_load(base + off, lhu, cached, !cached);
    end
    issue_load(base, lw, cached, !cached);
  endtask

  assign load_uncached = !is_cacheable(load_addr);

  always_ff @(posedge clock) begin
    load_seen <= load_done;
    store_seen <= store_done;
    fetch_seen <= fetch_done;
    if (!load_valid || load_done) load_age <= 0;
    else load_age <= load_age + 1;
    if (!store_valid || store_done) store_age <= 0;
    else store_age <= store_age + 1;
    if (!fetch_valid || fetch_done) fetch_age <= 0;
    else fetch_age <= fetch_age + 1;
  end

  a_load_value: assert property (@(posedge clock) disable iff (reset)
    load_done |-> load_data == exp_load)
    else stop_run($sformatf("Mismatch at %0t: load_data is %h, expected %h",
                            $time, $sampled(load_data), $sampled(exp_load)));

  a_fetch_value: assert property (@(posedge clock) disable iff (reset)
    fetch_done |-> fetch_instr == exp_fetch)
    else stop_run($sformatf("Mismatch at %0t: fetch_instr is %h, expected %h",
                            $time, $sampled(fetch_instr), $sampled(exp_fetch)));

  a_load_hit: assert property (@(posedge clock) disable iff (reset)
    load_valid && want_hit |-> load_done)
    else stop_run("a cached load did not finish in its first cycle");

  a_uncached_no_hit: assert property (@(posedge clock) disable iff (reset)
    load_valid && load_uncached && load_age == 0 |-> !load_done)
    else stop_run("an uncached load finished in its first cycle");

  a_load_miss: assert property (@(posedge clock) disable iff (reset)
    load_done && want_miss |-> load_age >= mem_latency)
    else stop_run("a load that should miss finished too early");

  a_store_done: assert property (@(posedge clock) disable iff (reset)
    store_done |-> store_valid && store_age >= mem_latency)
    else stop_run("a store finished without a request or before the memory took it");

  a_fetch_hit: assert property (@(posedge clock) disable iff (reset)
    fetch_valid && want_fetch_hit |-> fetch_done)
    else stop_run("a repeated fetch did not finish in its first cycle");

  a_fetch_miss: assert property (@(posedge clock) disable iff (reset)
    fetch_done && want_fetch_miss |-> fetch_age >= mem_latency)
    else stop_run("a fetch that should miss finished too early");

  a_load_bound: assert property (@(posedge clock) disable iff (reset)
    load_valid |-> load_age < max_wait)
    else stop_run("a load waited longer than the arbitration bound");

  a_fetch_bound: assert property (@(posedge clock) disable iff (reset)
    fetch_valid |-> fetch_age < max_wait)
    else stop_run("a fetch waited longer than the arbitration bound");

  initial begin
    reset = 1'b1;
    data_invalidate = 1'b0;
    inst_invalidate = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_op = lw;
    store_valid = 1'b0;
    store_addr = '0;
    store_data = '0;
    store_op = sw;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    want_hit = 1'b0;
    want_miss = 1'b0;
    want_fetch_hit = 1'b0;
    want_fetch_miss = 1'b0;
    exp_load = '0;
    exp_fetch = '0;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // a and b sit on different lines, u is far from both
    word_a = int'(draw_bits(4));
    word_b = 16 + (word_a + 5) % 16;
    word_u = 512 + int'(draw_bits(5));
    addr_a = 32'h8000_0000 + 32'(word_a * 4);
    addr_b = 32'h8000_0000 + 32'(word_b * 4);
    addr_u = 32'h1000_0000 + 32'(word_u * 4);

    issue_store(addr_a, draw_bits(32), sw);
    issue_store(addr_b, draw_bits(32), sw);
    issue_store(addr_u, draw_bits(32), sw);
    check_every_lane(addr_a, 1'b1);
    check_every_lane(addr_u, 1'b0);

    // narrow stores kill the line, sw brings it back
    rand_lane = 2'(draw_bits(2));
    rand_word = draw_bits(32);
    issue_store(addr_a + 32'(rand_lane), rand_word, sb);
    issue_load(addr_a, lw, 1'b0, 1'b1);
    rand_lane = {1'(draw_bits(1)), 1'b0};
    rand_word = draw_bits(32);
    issue_store(addr_a + 32'(rand_lane), rand_word, sh);
    issue_load(addr_a + 32'(rand_lane), lhu, 1'b0, 1'b1);
    rand_word = draw_bits(32);
    issue_store(addr_a, rand_word, sw);
    issue_load(addr_a, lw, 1'b1, 1'b0);
    issue_load(addr_a + 32'd2, lh, 1'b1, 1'b0);

    pulse_invalidate(1'b0);
    issue_load(addr_b, lw, 1'b0, 1'b1);
    issue_load(addr_b, lw, 1'b1, 1'b0);
    issue_fetch(addr_b, 1'b0, 1'b1);
    issue_fetch(addr_b, 1'b1, 1'b0);
    pulse_invalidate(1'b1);
    issue_fetch(addr_b, 1'b0, 1'b1);

    // both caches compete for the bus
    fork
      issue_fetch(addr_a, 1'b0, 1'b1);
      issue_load(addr_u, lw, 1'b0, 1'b1);
    join
    issue_fetch(addr_a, 1'b1, 1'b0);

    @(negedge clock);
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- logic/mem_top.sv
`timescale 1ns/1ns

module mem_top #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 1024
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     data_invalidate,
  input  logic                     inst_invalidate,
  input  logic                     load_valid,
  input  logic [mem_pkg::xlen-1:0] load_addr,
  input  mem_pkg::load_op_t        load_op,
  output logic                     load_done,
  output logic [mem_pkg::xlen-1:0] load_data,
  input  logic                     store_valid,
  input  logic [mem_pkg::xlen-1:0] store_addr,
  input  logic [mem_pkg::xlen-1:0] store_data,
  input  mem_pkg::store_op_t       store_op,
  output logic                     store_done,
  input  logic                     fetch_valid,
  input  logic [mem_pkg::xlen-1:0] fetch_pc,
  output logic                     fetch_done,
  output logic [mem_pkg::xlen-1:0] fetch_instr
);
  import mem_pkg::*;

  bus_req_t  data_req, inst_req, mem_req;
  bus_resp_t data_resp, inst_resp, mem_resp;

  lsu_l1d l1d (
    .clock, .reset, .invalidate(data_invalidate),
    .load_valid, .load_addr, .load_op, .load_done, .load_data,
    .store_valid, .store_addr, .store_data, .store_op, .store_done,
    .bus_req(data_req), .bus_resp(data_resp)
  );

  ifu_l1i l1i (
    .clock, .reset, .invalidate(inst_invalidate),
    .fetch_valid, .fetch_pc, .fetch_done, .fetch_instr,
    .bus_req(inst_req), .bus_resp(inst_resp)
  );

  bus_arbiter arbiter (
    .clock, .reset, .data_req, .data_resp, .inst_req, .inst_resp, .mem_req, .mem_resp
  );

  bus_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_WORDS(MEM_WORDS)) memory (
    .clock, .reset, .req(mem_req), .resp(mem_resp)
  );

endmodule

//--- logic/bus_memory.sv
`timescale 1ns/1ns

module bus_memory #(
  parameter int MEM_LATENCY = 3,
  parameter int MEM_WORDS   = 1024
) (
  input  logic               clock,
  input  logic               reset,
  input  mem_pkg::bus_req_t  req,
  output mem_pkg::bus_resp_t resp
);
  import mem_pkg::*;

  localparam int addr_bits = $clog2(MEM_WORDS);
  localparam int count_bits = $clog2(MEM_LATENCY + 1);

  logic [xlen-1:0]       mem [MEM_WORDS];
  logic [count_bits-1:0] count;
  logic [addr_bits-1:0]  word;

  // aliases by low bits
  assign word = req.addr[addr_bits+1:2];

  assign resp.ack   = req.valid && (count == count_bits'(MEM_LATENCY));
  assign resp.rdata = mem[word];

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (resp.ack) begin
      count <= '0;
    end else if (req.valid) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (resp.ack && req.write) begin
      for (int b = 0; b < 4; b++) begin
        if (req.strb[b]) mem[word][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
  end

  // count only runs while one request is held
  a_count_bound: assert property (
    @(posedge clock) disable iff (reset)
    (count <= count_bits'(MEM_LATENCY)) && ((count == '0) || req.valid));

endmodule

//--- logic/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
  input  logic               clock,
  input  logic               reset,
  input  mem_pkg::bus_req_t  data_req,
  output mem_pkg::bus_resp_t data_resp,
  input  mem_pkg::bus_req_t  inst_req,
  output mem_pkg::bus_resp_t inst_resp,
  output mem_pkg::bus_req_t  mem_req,
  input  mem_pkg::bus_resp_t mem_resp
);
  logic busy;
  logic owner;  // 1 = inst side
  logic last;
  logic sel;

  always_comb begin
    if (busy) begin
      sel = owner;
    end else if (data_req.valid && inst_req.valid) begin
      sel = !last;  // tie goes to the one not served last
    end else begin
      sel = inst_req.valid;
    end
  end

  assign mem_req = sel ? inst_req : data_req;

  always_comb begin
    data_resp = mem_resp;
    inst_resp = mem_resp;
    data_resp.ack = mem_resp.ack && !sel;
    inst_resp.ack = mem_resp.ack && sel;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      owner <= 1'b0;
      last  <= 1'b1;
    end else if (mem_resp.ack) begin
      busy <= 1'b0;
      last <= sel;
    end else if (!busy && mem_req.valid) begin
      busy  <= 1'b1;
      owner <= sel;
    end
  end

  // owner keeps the bus and its request until the ack
  a_owner_locked: assert property (
    @(posedge clock) disable iff (reset)
    mem_req.valid && !mem_resp.ack |=> mem_req.valid && (sel == $past(sel)));

endmodule

//--- logic/ifu_l1i.sv
`timescale 1ns/1ns

module ifu_l1i (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     invalidate,
  input  logic                     fetch_valid,
  input  logic [mem_pkg::xlen-1:0] fetch_pc,
  output logic                     fetch_done,
  output logic [mem_pkg::xlen-1:0] fetch_instr,
  output mem_pkg::bus_req_t        bus_req,
  input  mem_pkg::bus_resp_t       bus_resp
);
  import mem_pkg::*;

  localparam int lines = 2 ** index_bits;
  localparam int tag_bits = xlen - index_bits - 2;

  typedef enum logic [1:0] {
    s_idle,
    s_miss,
    s_wait
  } state_t;

  state_t state;

  logic [xlen-1:0]     line_data [lines];
  logic [tag_bits-1:0] line_tag  [lines];
  logic [lines-1:0]    line_valid;

  mem_addr_u       pc;
  mem_addr_u       miss_pc;
  logic [xlen-1:0] fill_data;
  logic            hit;

  assign pc.flat = fetch_pc;
  assign hit = line_valid[pc.fields.index] && (line_tag[pc.fields.index] == pc.fields.tag);

  assign fetch_done = fetch_valid && (((state == s_idle) && hit)
                                   || ((state == s_miss) && bus_resp.ack));
  assign fetch_instr = (state == s_idle) ? line_data[pc.fields.index] : bus_resp.rdata;

  // read-only, aligned word
  assign bus_req.valid = (state == s_miss);
  assign bus_req.write = 1'b0;
  assign bus_req.addr  = {miss_pc.flat[xlen-1:2], 2'b00};
  assign bus_req.wdata = '0;
  assign bus_req.strb  = 4'hf;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle:  if (fetch_valid && !hit) state <= s_miss;
        s_miss:  if (bus_resp.ack) state <= s_wait;
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == s_idle) miss_pc <= pc;
    if ((state == s_miss) && bus_resp.ack) fill_data <= bus_resp.rdata;
    if (state == s_wait) begin  // fill one edge after ack
      line_data[miss_pc.fields.index] <= fill_data;
      line_tag[miss_pc.fields.index]  <= miss_pc.fields.tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || invalidate) begin
      line_valid <= '0;
    end else if (state == s_wait) begin
      line_valid[miss_pc.fields.index] <= 1'b1;
    end
  end

  // a miss reads the word of the pc that is still held
  a_never_writes: assert property (
    @(posedge clock) disable iff (reset)
    bus_req.valid |-> !bus_req.write && (bus_req.addr[xlen-1:2] == fetch_pc[xlen-1:2]));

endmodule

//--- logic/lsu_l1d.sv
`timescale 1ns/1ns

module lsu_l1d (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       invalidate,
  input  logic                       load_valid,
  input  logic [mem_pkg::xlen-1:0]   load_addr,
  input  mem_pkg::load_op_t          load_op,
  output logic                       load_done,
  output logic [mem_pkg::xlen-1:0]   load_data,
  input  logic                       store_valid,
  input  logic [mem_pkg::xlen-1:0]   store_addr,
  input  logic [mem_pkg::xlen-1:0]   store_data,
  input  mem_pkg::store_op_t         store_op,
  output logic                       store_done,
  output mem_pkg::bus_req_t          bus_req,
  input  mem_pkg::bus_resp_t         bus_resp
);
  import mem_pkg::*;

  localparam int lines = 2 ** index_bits;
  localparam int tag_bits = xlen - index_bits - 2;

  typedef enum logic [1:0] {
    s_idle,
    s_load,
    s_store,
    s_wait
  } state_t;

  state_t state;

  logic [xlen-1:0]     line_data [lines];
  logic [tag_bits-1:0] line_tag  [lines];
  logic [lines-1:0]    line_valid;

  mem_addr_u       ld_addr;
  mem_addr_u       req_addr;
  bus_req_t        req_q;
  store_op_t       req_store_op;
  logic            req_cacheable;
  logic [xlen-1:0] fill_data;
  logic            hit;
  logic            req_hit;
  logic            fill;
  logic            alloc;
  logic            kill;

  function automatic logic [xlen-1:0] extend_load(input logic [xlen-1:0] word,
                                                  input logic [1:0] offset,
                                                  input load_op_t op);
    logic [xlen-1:0] lane;
    lane = word >> {offset, 3'b000};
    case (op)
      lb:      return {{24{lane[7]}}, lane[7:0]};
      lbu:     return {24'h0, lane[7:0]};
      lh:      return {{16{lane[15]}}, lane[15:0]};
      lhu:     return {16'h0, lane[15:0]};
      default: return lane;
    endcase
  endfunction

  function automatic logic [3:0] load_strb(input load_op_t op, input logic [1:0] offset);
    logic [3:0] base;
    case (op)
      lb, lbu: base = 4'b0001;
      lh, lhu: base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << offset;
  endfunction

  function automatic logic [3:0] store_strb(input store_op_t op, input logic [1:0] offset);
    logic [3:0] base;
    case (op)
      sb:      base = 4'b0001;
      sh:      base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << offset;
  endfunction

  function automatic logic [xlen-1:0] store_lanes(input store_op_t op,
                                                  input logic [xlen-1:0] data);
    case (op)
      sb:      return {4{data[7:0]}};
      sh:      return {2{data[15:0]}};
      default: return data;
    endcase
  endfunction

  assign ld_addr.flat  = load_addr;
  assign req_addr.flat = req_q.addr;

  assign hit = is_cacheable(load_addr) && line_valid[ld_addr.fields.index]
             && (line_tag[ld_addr.fields.index] == ld_addr.fields.tag);
  assign req_hit = line_valid[req_addr.fields.index]
                 && (line_tag[req_addr.fields.index] == req_addr.fields.tag);

  assign load_done = load_valid && (((state == s_idle) && hit)
                                 || ((state == s_load) && bus_resp.ack));
  assign load_data = extend_load((state == s_idle) ? line_data[ld_addr.fields.index]
                                                   : bus_resp.rdata,
                                 ld_addr.fields.offset, load_op);
  assign store_done = (state == s_store) && bus_resp.ack;

  always_comb begin
    bus_req = req_q;
    bus_req.valid = (state == s_load) || (state == s_store);
  end

  // line updates
  assign fill  = (state == s_wait) && !req_q.write && req_cacheable;
  assign alloc = store_done && req_cacheable && (req_store_op == sw);
  assign kill  = store_done && req_cacheable && (req_store_op != sw) && req_hit;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (load_valid) begin
            if (!hit) state <= s_load;
          end else if (store_valid) begin
            state <= s_store;
          end
        end
        s_load:  if (bus_resp.ack) state <= s_wait;
        s_store: if (bus_resp.ack) state <= s_wait;
        default: state <= s_idle;  // wait state
      endcase
    end
  end

  // request latch, load has priority
  always_ff @(posedge clock) begin
    if (state == s_idle) begin
      if (load_valid) begin
        req_q.valid   <= 1'b1;
        req_q.write   <= 1'b0;
        req_q.addr    <= is_cacheable(load_addr) ? {load_addr[xlen-1:2], 2'b00} : load_addr;
        req_q.wdata   <= '0;
        req_q.strb    <= is_cacheable(load_addr) ? 4'hf
                                                 : load_strb(load_op, ld_addr.fields.offset);
        req_cacheable <= is_cacheable(load_addr);
      end else if (store_valid) begin
        req_q.valid   <= 1'b1;
        req_q.write   <= 1'b1;
        req_q.addr    <= store_addr;
        req_q.wdata   <= store_lanes(store_op, store_data);
        req_q.strb    <= store_strb(store_op, store_addr[1:0]);
        req_store_op  <= store_op;
        req_cacheable <= is_cacheable(store_addr);
      end
    end
    if ((state == s_load) && bus_resp.ack) fill_data <= bus_resp.rdata;
  end

  always_ff @(posedge clock) begin
    if (fill || alloc) begin
      line_data[req_addr.fields.index] <= fill ? fill_data : req_q.wdata;
      line_tag[req_addr.fields.index]  <= req_addr.fields.tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || invalidate) begin
      line_valid <= '0;
    end else if (fill || alloc) begin
      line_valid[req_addr.fields.index] <= 1'b1;
    end else if (kill) begin
      line_valid[req_addr.fields.index] <= 1'b0;  // narrow store hit
    end
  end

  // a bus done must belong to the load that is still held
  a_done_needs_valid: assert property (
    @(posedge clock) disable iff (reset)
    load_done |-> load_valid && ((state == s_idle)
                                 || (req_q.addr[xlen-1:2] == load_addr[xlen-1:2])));

  a_req_stable: assert property (
    @(posedge clock) disable iff (reset)
    bus_req.valid && !bus_resp.ack |=> $stable(bus_req));

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

  localparam int xlen = 32;
  localparam int index_bits = 4;

  // one address word, seen flat or as cache fields
  typedef union packed {
    logic [xlen-1:0] flat;
    struct packed {
      logic [xlen-index_bits-3:0] tag;
      logic [index_bits-1:0]      index;
      logic [1:0]                 offset;
    } fields;
  } mem_addr_u;

  typedef enum logic [2:0] {
    lb,
    lbu,
    lh,
    lhu,
    lw
  } load_op_t;

  typedef enum logic [1:0] {
    sb,
    sh,
    sw
  } store_op_t;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      strb;
  } bus_req_t;

  typedef struct packed {
    logic            ack;  // single cycle
    logic [xlen-1:0] rdata;
  } bus_resp_t;

  // psram window only
  function automatic logic is_cacheable(input logic [xlen-1:0] addr);
    return (addr >= 32'h8000_0000) && (addr < 32'h8800_0000);
  endfunction

endpackage
